//--- dram_bridge_config.svh
`ifndef DRAM_BRIDGE_CONFIG_SVH
`define DRAM_BRIDGE_CONFIG_SVH

// ----------------------------------------
// bridge geometry
// ----------------------------------------

// number of lane engines, one app channel each
`define DRAM_LANES 4

// app address width of every channel, higher CPU address bits are out of range
`define DRAM_APP_ADDR_W 27

// lowest CPU address bit of the lane index, right above the 16-byte beat offset
`define DRAM_LANE_LSB 4

`endif

//--- dram_bridge_pkg.sv
`include "dram_bridge_config.svh"

package dram_bridge_pkg;

  // ----------------------------------------
  // CPU side
  // ----------------------------------------

  typedef struct packed {
    logic        mem_valid;
    logic        mem_instr;
    logic [31:0] mem_addr;
    logic [63:0] mem_wdata;
    logic [7:0]  mem_wstrb;  // all zero means a read
  } mem_in_t;

  typedef struct packed {
    logic        mem_ready;
    logic        mem_error;
    logic [63:0] mem_rdata;
  } mem_out_t;

  // result of one lane towards the merger
  typedef struct packed {
    logic        done;
    logic [63:0] rdata;
  } lane_rsp_t;

  // ----------------------------------------
  // app channel side
  // ----------------------------------------

  typedef enum logic [2:0] {
    app_cmd_write = 3'b000,
    app_cmd_read  = 3'b001
  } app_cmd_e;

  typedef struct packed {
    logic [`DRAM_APP_ADDR_W-1:0] app_addr;
    app_cmd_e                    app_cmd;
    logic                        app_en;
    logic [127:0]                app_wdf_data;
    logic [15:0]                 app_wdf_mask;  // a set bit keeps that byte
    logic                        app_wdf_wren;
    logic                        app_wdf_end;
  } app_req_t;

  typedef struct packed {
    logic         app_rdy;
    logic         app_wdf_rdy;
    logic [127:0] app_rd_data;
    logic         app_rd_data_valid;
    logic         app_rd_data_end;
  } app_rsp_t;

  typedef enum logic [2:0] {
    lane_idle,
    lane_preset,
    lane_send_data,
    lane_cmd_wr,
    lane_cmd_rd,
    lane_wait_done,
    lane_release
  } lane_state_e;

endpackage

//--- request_dispatch.sv
`timescale 1ns/10ps
`include "dram_bridge_config.svh"

module request_dispatch (
  input  logic                     app_ui_clk,
  input  logic                     app_ui_rst,
  input  dram_bridge_pkg::mem_in_t mem_in,
  output logic [`DRAM_LANES-1:0]   lane_valid,
  output dram_bridge_pkg::mem_in_t lane_req,
  output logic                     addr_error
);

  localparam int LANE_W = $clog2(`DRAM_LANES);

  logic [LANE_W-1:0] lane_idx;
  logic              in_range;
  logic              seen;

  // ----------------------------------------
  // decode
  // ----------------------------------------

  assign lane_idx = mem_in.mem_addr[`DRAM_LANE_LSB +: LANE_W];
  assign in_range = ~|mem_in.mem_addr[31:`DRAM_APP_ADDR_W];

  // every lane sees the same request, only the addressed one gets a valid
  assign lane_req = mem_in;

  always_comb begin
    lane_valid = '0;
    if (mem_in.mem_valid && in_range) begin
      lane_valid[lane_idx] = 1'b1;
    end
  end

  // ----------------------------------------
  // range error, once per request
  // ----------------------------------------

  // seen follows mem_valid one cycle late, so the error fires on the rising edge only
  always_ff @(posedge app_ui_clk) begin
    if (app_ui_rst) begin
      seen       <= 1'b0;
      addr_error <= 1'b0;
    end else begin
      seen       <= mem_in.mem_valid;
      addr_error <= mem_in.mem_valid && !in_range && !seen;
    end
  end

  a_lane_onehot : assert property (
    @(posedge app_ui_clk) disable iff (app_ui_rst)
    $onehot0(lane_valid)
  );

  // a request that errors must never reach a lane
  a_error_no_lane : assert property (
    @(posedge app_ui_clk) disable iff (app_ui_rst)
    addr_error |-> lane_valid == '0
  );

endmodule

//--- lane_engine.sv
`timescale 1ns/10ps
`include "dram_bridge_config.svh"

module lane_engine (
  input  logic                       app_ui_clk,
  input  logic                       app_ui_rst,
  input  logic                       calib_complete,
  input  logic                       lane_valid,
  input  dram_bridge_pkg::mem_in_t   lane_req,
  output dram_bridge_pkg::app_req_t  app_req,
  input  dram_bridge_pkg::app_rsp_t  app_rsp,
  output dram_bridge_pkg::lane_rsp_t lane_rsp
);

  import dram_bridge_pkg::*;

  lane_state_e                 state;
  lane_state_e                 state_nxt;
  mem_in_t                     req_q;
  logic                        is_write;
  logic                        wr_done;
  logic                        rd_done;
  logic                        done_q;
  logic [63:0]                 rdata_q;
  logic [`DRAM_APP_ADDR_W-1:0] beat_addr;
  logic [127:0]                beat_data;
  logic [15:0]                 beat_mask;

  assign is_write = |req_q.mem_wstrb;
  assign wr_done  = (state == lane_cmd_wr) && app_rsp.app_rdy;  // write ends on command accept
  assign rd_done  = (state == lane_wait_done) && app_rsp.app_rd_data_valid
                    && app_rsp.app_rd_data_end;

  // ----------------------------------------
  // sequencing
  // ----------------------------------------

  always_comb begin
    state_nxt = state;
    case (state)
      lane_idle: begin
        if (lane_valid && calib_complete) begin
          state_nxt = lane_preset;
        end
      end
      lane_preset: begin
        state_nxt = is_write ? lane_send_data : lane_cmd_rd;
      end
      lane_send_data: begin
        if (app_rsp.app_wdf_rdy) begin
          state_nxt = lane_cmd_wr;
        end
      end
      lane_cmd_wr: begin
        if (app_rsp.app_rdy) begin
          state_nxt = lane_release;
        end
      end
      lane_cmd_rd: begin
        if (app_rsp.app_rdy) begin
          state_nxt = lane_wait_done;
        end
      end
      lane_wait_done: begin
        if (rd_done) begin
          state_nxt = lane_release;
        end
      end
      lane_release: begin
        // hold here until the CPU has seen mem_ready and dropped its valid
        if (!lane_valid) begin
          state_nxt = lane_idle;
        end
      end
      default: begin
        state_nxt = lane_idle;
      end
    endcase
  end

  always_ff @(posedge app_ui_clk) begin
    if (app_ui_rst) begin
      state  <= lane_idle;
      done_q <= 1'b0;
    end else begin
      state  <= state_nxt;
      done_q <= wr_done || rd_done;
    end
  end

  // ----------------------------------------
  // request, beat and read data
  // ----------------------------------------

  always_ff @(posedge app_ui_clk) begin
    if (state == lane_idle && lane_valid) begin
      req_q <= lane_req;
    end
    if (state == lane_preset) begin
      beat_addr <= {req_q.mem_addr[`DRAM_APP_ADDR_W-1:4], 4'b0000};
      beat_data <= {2{req_q.mem_wdata}};
      // mem_addr[3] picks the half that takes the strobes, the other half is masked off
      beat_mask <= req_q.mem_addr[3] ? {~req_q.mem_wstrb, 8'hff}
                                     : {8'hff, ~req_q.mem_wstrb};
    end
    if (rd_done) begin
      rdata_q <= req_q.mem_addr[3] ? app_rsp.app_rd_data[127:64]
                                   : app_rsp.app_rd_data[63:0];
    end
  end

  always_comb begin
    app_req.app_addr     = beat_addr;
    app_req.app_cmd      = (state == lane_cmd_rd) ? app_cmd_read : app_cmd_write;
    app_req.app_en       = (state == lane_cmd_wr) || (state == lane_cmd_rd);
    app_req.app_wdf_data = beat_data;
    app_req.app_wdf_mask = beat_mask;
    app_req.app_wdf_wren = (state == lane_send_data);
    app_req.app_wdf_end  = (state == lane_send_data);  // one beat per burst
  end

  always_comb begin
    lane_rsp.done  = done_q;
    lane_rsp.rdata = rdata_q;
  end

  // ----------------------------------------
  // app protocol checks
  // ----------------------------------------

  a_en_wren_excl : assert property (
    @(posedge app_ui_clk) disable iff (app_ui_rst)
    !(app_req.app_en && app_req.app_wdf_wren)
  );

  a_en_held : assert property (
    @(posedge app_ui_clk) disable iff (app_ui_rst)
    app_req.app_en && !app_rsp.app_rdy |=>
      app_req.app_en && $stable(app_req.app_addr) && $stable(app_req.app_cmd)
  );

endmodule

//--- response_merge.sv
`timescale 1ns/10ps
`include "dram_bridge_config.svh"

module response_merge (
  input  logic                       app_ui_clk,
  input  logic                       app_ui_rst,
  input  dram_bridge_pkg::lane_rsp_t lane_rsp [`DRAM_LANES],
  input  logic                       addr_error,
  output dram_bridge_pkg::mem_out_t  mem_out
);

  logic [`DRAM_LANES-1:0] done_vec;
  logic [63:0]            rdata_mux;

  // and-or mux, only the finished lane contributes
  always_comb begin
    rdata_mux = '0;
    for (int i = 0; i < `DRAM_LANES; i++) begin
      done_vec[i] = lane_rsp[i].done;
      if (lane_rsp[i].done) begin
        rdata_mux = rdata_mux | lane_rsp[i].rdata;
      end
    end
  end

  // ----------------------------------------
  // registered CPU response
  // ----------------------------------------

  always_ff @(posedge app_ui_clk) begin
    if (app_ui_rst) begin
      mem_out.mem_ready <= 1'b0;
      mem_out.mem_error <= 1'b0;
    end else begin
      mem_out.mem_ready <= (|done_vec) || addr_error;
      mem_out.mem_error <= addr_error;
    end
    mem_out.mem_rdata <= rdata_mux;
  end

  // one request in flight, so lanes never finish together
  a_done_single : assert property (
    @(posedge app_ui_clk) disable iff (app_ui_rst)
    $onehot0(done_vec)
  );

endmodule

//--- dram_bridge_top.sv
`timescale 1ns/10ps
`include "dram_bridge_config.svh"

module dram_bridge_top (
  input  logic                      app_ui_clk,
  input  logic                      app_ui_rst,
  input  logic                      calib_complete,
  input  dram_bridge_pkg::mem_in_t  mem_in,
  output dram_bridge_pkg::mem_out_t mem_out,
  output dram_bridge_pkg::app_req_t app_req [`DRAM_LANES],
  input  dram_bridge_pkg::app_rsp_t app_rsp [`DRAM_LANES]
);

  import dram_bridge_pkg::*;

  logic [`DRAM_LANES-1:0] lane_valid;
  mem_in_t                lane_req;
  logic                   addr_error;
  lane_rsp_t              lane_rsp [`DRAM_LANES];

  request_dispatch u_dispatch (
    .app_ui_clk (app_ui_clk),
    .app_ui_rst (app_ui_rst),
    .mem_in     (mem_in),
    .lane_valid (lane_valid),
    .lane_req   (lane_req),
    .addr_error (addr_error)
  );

  // ----------------------------------------
  // one engine per app channel
  // ----------------------------------------

  for (genvar i = 0; i < `DRAM_LANES; i++) begin : g_lane
    lane_engine u_lane (
      .app_ui_clk     (app_ui_clk),
      .app_ui_rst     (app_ui_rst),
      .calib_complete (calib_complete),
      .lane_valid     (lane_valid[i]),
      .lane_req       (lane_req),
      .app_req        (app_req[i]),
      .app_rsp        (app_rsp[i]),
      .lane_rsp       (lane_rsp[i])
    );
  end

  response_merge u_merge (
    .app_ui_clk (app_ui_clk),
    .app_ui_rst (app_ui_rst),
    .lane_rsp   (lane_rsp),
    .addr_error (addr_error),
    .mem_out    (mem_out)
  );

endmodule

//--- tb_app_channel.sv
`timescale 1ns/10ps
`include "dram_bridge_config.svh"

module tb_app_channel (
  input  logic                      app_ui_clk,
  input  logic                      app_ui_rst,
  input  dram_bridge_pkg::app_req_t app_req,
  output dram_bridge_pkg::app_rsp_t app_rsp,
  input  logic [3:0]                stall,  // [0] app_rdy low, [1] app_wdf_rdy low, [3:2] read delay
  output int                        cmd_count,
  output int                        beat_count,
  output dram_bridge_pkg::app_req_t last_beat,
  output logic                      order_error
);

  import dram_bridge_pkg::*;

  logic [127:0]                mem [logic [`DRAM_APP_ADDR_W-1:0]];
  logic [127:0]                beat_tmp;
  logic                        data_pending;
  int                          rd_wait;
  logic [`DRAM_APP_ADDR_W-1:0] rd_addr;
  logic                        rd_valid;
  logic [127:0]                rd_data;

  always_comb begin
    app_rsp.app_rdy           = !stall[0];
    app_rsp.app_wdf_rdy       = !stall[1];
    app_rsp.app_rd_data       = rd_data;
    app_rsp.app_rd_data_valid = rd_valid;
    app_rsp.app_rd_data_end   = rd_valid;  // single beat bursts only
  end

  // ----------------------------------------
  // data path, commands and read returns
  // ----------------------------------------

  always @(posedge app_ui_clk) begin
    if (app_ui_rst) begin
      cmd_count    <= 0;
      beat_count   <= 0;
      data_pending <= 1'b0;
      order_error  <= 1'b0;
      rd_wait      <= 0;
      rd_valid     <= 1'b0;
    end else begin
      rd_valid <= 1'b0;
      if (app_req.app_wdf_wren && app_rsp.app_wdf_rdy) begin
        last_beat    <= app_req;
        beat_count   <= beat_count + 1;
        data_pending <= 1'b1;
      end
      if (app_req.app_en && app_rsp.app_rdy) begin
        cmd_count <= cmd_count + 1;
        if (app_req.app_cmd == app_cmd_write) begin
          // a write command with no beat waiting means the order was broken
          if (!data_pending) begin
            order_error <= 1'b1;
          end
          beat_tmp = mem.exists(app_req.app_addr) ? mem[app_req.app_addr] : '0;
          for (int b = 0; b < 16; b++) begin
            if (!last_beat.app_wdf_mask[b]) begin
              beat_tmp[8*b +: 8] = last_beat.app_wdf_data[8*b +: 8];
            end
          end
          mem[app_req.app_addr] = beat_tmp;
          data_pending <= 1'b0;
        end else begin
          rd_addr <= app_req.app_addr;
          rd_wait <= 1 + stall[3:2];  // the beat shows up 2 to 5 cycles after the accept
        end
      end
      if (rd_wait == 1) begin
        rd_valid <= 1'b1;
        rd_data  <= mem.exists(rd_addr) ? mem[rd_addr] : '0;
      end
      if (rd_wait > 0) begin
        rd_wait <= rd_wait - 1;
      end
    end
  end

endmodule

//--- tb_dram_bridge.sv
`timescale 1ns/10ps
`include "dram_bridge_config.svh"

module tb_dram_bridge;

  import dram_bridge_pkg::*;

  localparam int LANE_W  = $clog2(`DRAM_LANES);
  localparam int NUM_REQ = 68;  // calib 1, full 16, partial 16, range 3, random 32

  logic        app_ui_clk;
  logic        app_ui_rst;
  logic        calib_complete;
  mem_in_t     mem_in;
  mem_out_t    mem_out;
  app_req_t    app_req [`DRAM_LANES];
  app_rsp_t    app_rsp [`DRAM_LANES];
  logic [3:0]  stall [`DRAM_LANES];
  logic [3:0]  stall_bits;
  int          cmd_count [`DRAM_LANES];
  int          beat_count [`DRAM_LANES];
  app_req_t    last_beat [`DRAM_LANES];
  logic        order_error [`DRAM_LANES];
  int          cmd_before [`DRAM_LANES];
  int          beat_before [`DRAM_LANES];
  logic [31:0] stim_lfsr  = 32'h19b2f988;
  logic [31:0] stall_lfsr = 32'h19b2f988;
  logic [63:0] shadow [logic [23:0]];  // 64-bit words keyed by mem_addr[26:3]
  mem_out_t    exp_q [$];
  bit          rd_q [$];

  dram_bridge_top dut (
    .app_ui_clk     (app_ui_clk),
    .app_ui_rst     (app_ui_rst),
    .calib_complete (calib_complete),
    .mem_in         (mem_in),
    .mem_out        (mem_out),
    .app_req        (app_req),
    .app_rsp        (app_rsp)
  );

  for (genvar i = 0; i < `DRAM_LANES; i++) begin : g_chan
    tb_app_channel u_chan (
      .app_ui_clk  (app_ui_clk),
      .app_ui_rst  (app_ui_rst),
      .app_req     (app_req[i]),
      .app_rsp     (app_rsp[i]),
      .stall       (stall[i]),
      .cmd_count   (cmd_count[i]),
      .beat_count  (beat_count[i]),
      .last_beat   (last_beat[i]),
      .order_error (order_error[i])
    );
  end

  initial begin
    app_ui_clk = 1'b0;
    forever #4 app_ui_clk = ~app_ui_clk;
  end

  // ----------------------------------------
  // random bits and the reference model
  // ----------------------------------------

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      v = {v[62:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  function automatic mem_out_t ref_access(input mem_in_t req);
    mem_out_t    rsp;
    logic [63:0] word;
    rsp = '0;
    rsp.mem_ready = 1'b1;
    if (|req.mem_addr[31:`DRAM_APP_ADDR_W]) begin
      rsp.mem_error = 1'b1;
      return rsp;
    end
    word = shadow.exists(req.mem_addr[26:3]) ? shadow[req.mem_addr[26:3]] : '0;
    for (int b = 0; b < 8; b++) begin
      if (req.mem_wstrb[b]) word[8*b +: 8] = req.mem_wdata[8*b +: 8];
    end
    if (req.mem_wstrb == 8'h00) rsp.mem_rdata = word;
    else shadow[req.mem_addr[26:3]] = word;
    return rsp;
  endfunction

  function automatic app_req_t expected_beat(input mem_in_t req);
    app_req_t b;
    b = '0;
    b.app_addr     = {req.mem_addr[`DRAM_APP_ADDR_W-1:4], 4'b0000};
    b.app_wdf_data = {2{req.mem_wdata}};
    b.app_wdf_mask = 16'hffff;
    if (req.mem_addr[3]) b.app_wdf_mask[15:8] = ~req.mem_wstrb;
    else b.app_wdf_mask[7:0] = ~req.mem_wstrb;
    b.app_wdf_wren = 1'b1;
    b.app_wdf_end  = 1'b1;
    return b;
  endfunction

  // ----------------------------------------
  // failure reporting and compares
  // ----------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    abort_run($sformatf("** Error: %s got %0h expected %0h", name, got, exp));
  endtask

  task automatic check_response(input mem_out_t got, input mem_out_t exp, input bit is_read);
    if (got.mem_error !== exp.mem_error) begin
      report_mismatch("mem_out.mem_error", got.mem_error, exp.mem_error);
    end
    if (is_read && got.mem_rdata !== exp.mem_rdata) begin
      report_mismatch("mem_out.mem_rdata", got.mem_rdata, exp.mem_rdata);
    end
  endtask

  task automatic check_beat(input app_req_t got, input app_req_t exp);
    if (got.app_addr !== exp.app_addr) begin
      report_mismatch("app_req.app_addr", got.app_addr, exp.app_addr);
    end
    if (got.app_wdf_data !== exp.app_wdf_data) begin
      report_mismatch("app_req.app_wdf_data", got.app_wdf_data, exp.app_wdf_data);
    end
    if (got.app_wdf_mask !== exp.app_wdf_mask) begin
      report_mismatch("app_req.app_wdf_mask", got.app_wdf_mask, exp.app_wdf_mask);
    end
    if (got.app_wdf_end !== exp.app_wdf_end) begin
      report_mismatch("app_req.app_wdf_end", got.app_wdf_end, exp.app_wdf_end);
    end
  endtask

  // every mem_ready pulse is matched against the oldest outstanding request
  always @(posedge app_ui_clk) begin
    if (!app_ui_rst && mem_out.mem_ready === 1'b1) begin
      if (exp_q.size() == 0) begin
        abort_run("mem_ready pulsed with no request outstanding");
      end else begin
        check_response(mem_out, exp_q.pop_front(), rd_q.pop_front());
      end
    end
  end

  // ready stalls and read delays for every channel
  always @(posedge app_ui_clk) begin
    for (int i = 0; i < `DRAM_LANES; i++) begin
      for (int b = 0; b < 4; b++) begin
        stall_lfsr    = lfsr_next(stall_lfsr);
        stall_bits[b] = stall_lfsr[0];
      end
      stall[i] <= stall_bits;
    end
  end

  initial begin
    repeat (16 + 10 + NUM_REQ * 200) @(posedge app_ui_clk);
    abort_run("watchdog expired before all requests completed");
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  task automatic start_request(input mem_in_t req);
    for (int i = 0; i < `DRAM_LANES; i++) begin
      cmd_before[i]  = cmd_count[i];
      beat_before[i] = beat_count[i];
    end
    rd_q.push_back(req.mem_wstrb == 8'h00 && ~|req.mem_addr[31:`DRAM_APP_ADDR_W]);
    exp_q.push_back(ref_access(req));
    @(posedge app_ui_clk);
    mem_in <= req;
  endtask

  task automatic finish_request(input mem_in_t req);
    int lane;
    bit in_range;
    bit is_write;
    int exp_cmds;
    int exp_beats;
    lane     = int'(req.mem_addr[`DRAM_LANE_LSB +: LANE_W]);
    in_range = ~|req.mem_addr[31:`DRAM_APP_ADDR_W];
    is_write = |req.mem_wstrb;
    do begin
      @(posedge app_ui_clk);
    end while (mem_out.mem_ready !== 1'b1);
    mem_in.mem_valid <= 1'b0;
    for (int i = 0; i < `DRAM_LANES; i++) begin
      exp_cmds  = cmd_before[i] + ((in_range && i == lane) ? 1 : 0);
      exp_beats = beat_before[i] + ((in_range && is_write && i == lane) ? 1 : 0);
      if (cmd_count[i] != exp_cmds) begin
        report_mismatch($sformatf("channel %0d cmd_count", i), cmd_count[i], exp_cmds);
      end
      if (beat_count[i] != exp_beats) begin
        report_mismatch($sformatf("channel %0d beat_count", i), beat_count[i], exp_beats);
      end
      if (order_error[i]) begin
        abort_run($sformatf("channel %0d got a write command before its data", i));
      end
    end
    if (in_range && is_write) check_beat(last_beat[lane], expected_beat(req));
  endtask

  task automatic run_request(input logic [31:0] addr, input logic [63:0] wdata,
                             input logic [7:0] wstrb);
    mem_in_t req;
    req = {1'b1, 1'b0, addr, wdata, wstrb};
    start_request(req);
    finish_request(req);
  endtask

  initial begin
    logic [31:0] addr;
    logic [7:0]  strb;
    mem_in_t     req;
    app_ui_rst     = 1'b1;
    calib_complete = 1'b0;
    mem_in         = '0;
    foreach (stall[i]) stall[i] = 4'h0;
    repeat (16) @(posedge app_ui_clk);
    app_ui_rst <= 1'b0;

    // the request is held while calibration is still running
    req = {1'b1, 1'b0, 32'h0000_2008, 64'h0123_4567_89ab_cdef, 8'hff};
    start_request(req);
    repeat (10) begin
      @(posedge app_ui_clk);
      if (mem_out.mem_ready !== 1'b0) abort_run("mem_ready rose before calib_complete");
    end
    calib_complete <= 1'b1;
    finish_request(req);

    // 8 words cover every lane and both beat halves
    for (int i = 0; i < 8; i++) run_request(32'h0000_1000 + i * 8, rand_bits(64), 8'hff);
    for (int i = 0; i < 8; i++) run_request(32'h0000_1000 + i * 8, 64'h0, 8'h00);
    for (int i = 0; i < 8; i++) begin
      strb = rand_bits(8);
      if (strb == 8'h00) strb = 8'h5a;
      run_request(32'h0000_1000 + i * 8, rand_bits(64), strb);
    end
    for (int i = 0; i < 8; i++) run_request(32'h0000_1000 + i * 8, 64'h0, 8'h00);

    run_request(32'h0800_0000, 64'h0, 8'h00);
    run_request(32'hf000_0010, rand_bits(64), 8'hff);
    run_request(32'h0000_1000, 64'h0, 8'h00);

    for (int n = 0; n < 32; n++) begin
      addr = 32'h0000_1000 | 32'(rand_bits(4) << 3);
      if (rand_bits(3) == 0) addr = addr | (32'h0800_0000 << rand_bits(2));
      strb = rand_bits(1) ? rand_bits(8) : 8'h00;
      run_request(addr, rand_bits(64), strb);
    end

    // a few idle cycles so a stray mem_ready still reaches the checker
    repeat (4) @(posedge app_ui_clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- sources.f
+incdir+.
dram_bridge_pkg.sv
request_dispatch.sv
lane_engine.sv
response_merge.sv
dram_bridge_top.sv
tb_app_channel.sv
tb_dram_bridge.sv
